//--- source/l2TilePkg.sv
package l2TilePkg;

	// ring message fields
	localparam int seqWidth = 16;
	localparam int opmWidth = 16;
	localparam int addrWidth = 48;
	localparam int wordWidth = 128;

	// DDR side
	localparam int tileWidth = 512;
	localparam int ddrAddrWidth = 32;
	localparam int ddrOpmWidth = 5;
	localparam int ddrOkWidth = 2;

	// line address is ring address bits 31..6
	localparam int lineAddrWidth = 26;

	// low byte of the operation word
	localparam logic [7:0] opIdle = 8'h00;
	localparam logic [7:0] opLoad = 8'h93;
	localparam logic [7:0] opStore = 8'hA3;
	localparam logic [7:0] opOkLoad = 8'h53;
	localparam logic [7:0] opOkStore = 8'h63;

	localparam logic [ddrOpmWidth-1:0] ddrReady = 5'h00;
	localparam logic [ddrOpmWidth-1:0] ddrReadTile = 5'h07;
	localparam logic [ddrOpmWidth-1:0] ddrWriteTile = 5'h0B;

	localparam logic [ddrOkWidth-1:0] ddrStReady = 2'b00;
	localparam logic [ddrOkWidth-1:0] ddrStOk = 2'b01;
	localparam logic [ddrOkWidth-1:0] ddrStHold = 2'b10;

	// DDR sees one flat tile, the cache sees four ring words
	typedef union packed {
		logic [tileWidth-1:0] flat;
		logic [3:0][wordWidth-1:0] word;
	} tile_u;

	function automatic logic isRamAddress(input logic [addrWidth-1:0] addr);
		return (addr[29:24] != 6'h00) && (addr[31:30] == 2'b00);
	endfunction

	function automatic logic [lineAddrWidth-1:0] lineAddress(input logic [addrWidth-1:0] addr);
		return addr[31:6];
	endfunction

	function automatic logic [1:0] wordSelect(input logic [addrWidth-1:0] addr);
		return addr[5:4];
	endfunction

	// caller truncates the result to its own index width
	function automatic logic [lineAddrWidth-1:0] lineIndex(
		input logic [lineAddrWidth-1:0] lineAddr,
		input int indexBits
	);
		logic [lineAddrWidth-1:0] mask;
		mask = (lineAddrWidth'(1) << indexBits) - lineAddrWidth'(1);
		return (lineAddr ^ (lineAddr >> indexBits)) & mask;
	endfunction

endpackage

//--- source/ringStages.sv
module ringStages (
	input logic clock,
	input logic reset,
	input logic [l2TilePkg::seqWidth-1:0] seqIn,
	input logic [l2TilePkg::opmWidth-1:0] opmIn,
	input logic [l2TilePkg::addrWidth-1:0] addrIn,
	input logic [l2TilePkg::wordWidth-1:0] dataIn,
	output logic [l2TilePkg::seqWidth-1:0] seqOut,
	output logic [l2TilePkg::opmWidth-1:0] opmOut,
	output logic [l2TilePkg::addrWidth-1:0] addrOut,
	output logic [l2TilePkg::wordWidth-1:0] dataOut,
	input logic respond,
	input logic [l2TilePkg::wordWidth-1:0] respondWord,
	output logic [l2TilePkg::opmWidth-1:0] stage2Opm,
	output logic [l2TilePkg::addrWidth-1:0] stage2Addr,
	output logic [l2TilePkg::wordWidth-1:0] stage2Data,
	output logic stage2RamReq
);
	import l2TilePkg::*;

	logic inRamReq;
	logic [seqWidth-1:0] stage2Seq;
	logic [seqWidth-1:0] stage3Seq;
	logic [opmWidth-1:0] stage3Opm;
	logic [addrWidth-1:0] stage3Addr;
	logic [wordWidth-1:0] stage3Data;
	logic [7:0] okCode;

	// only loads and stores into RAM space are served here
	assign inRamReq = ((opmIn[7:0] == opLoad) || (opmIn[7:0] == opStore)) &&
		isRamAddress(addrIn);

	assign okCode = (stage3Opm[7:0] == opStore) ? opOkStore : opOkLoad;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			stage2Opm <= {8'h00, opIdle};
			stage2RamReq <= 1'b0;
			stage3Opm <= {8'h00, opIdle};
			opmOut <= {8'h00, opIdle};
		end
		else
		begin
			stage2Opm <= opmIn;
			stage2RamReq <= inRamReq;
			stage3Opm <= stage2Opm;
			// response keeps the upper opm byte
			if (respond)
				opmOut <= {stage3Opm[15:8], okCode};
			else
				opmOut <= stage3Opm;
		end
	end

	always_ff @(posedge clock)
	begin
		stage2Seq <= seqIn;
		stage2Addr <= addrIn;
		stage2Data <= dataIn;
		stage3Seq <= stage2Seq;
		stage3Addr <= stage2Addr;
		stage3Data <= stage2Data;
		seqOut <= stage3Seq;
		addrOut <= stage3Addr;
		if (respond)
			dataOut <= respondWord;
		else
			dataOut <= stage3Data;
	end

endmodule

//--- source/lineStore.sv
module lineStore #(
	parameter int IndexBits = 6
) (
	input logic clock,
	input logic reset,
	input logic [l2TilePkg::addrWidth-1:0] readAddr,
	output l2TilePkg::tile_u readLine,
	output logic [l2TilePkg::lineAddrWidth-1:0] readTag,
	output logic readValid,
	output logic readDirty,
	output logic [IndexBits-1:0] readIndex,
	input logic writeEnable,
	input logic [IndexBits-1:0] writeIndex,
	input l2TilePkg::tile_u writeLine,
	input logic [l2TilePkg::lineAddrWidth-1:0] writeTag,
	input logic writeDirty
);
	import l2TilePkg::*;

	localparam int Lines = 1 << IndexBits;

	tile_u dataArray [Lines];
	logic [lineAddrWidth-1:0] tagArray [Lines];
	logic [Lines-1:0] dirtyBits;
	logic [Lines-1:0] validBits;
	logic [IndexBits-1:0] addrIndex;

	// hashed index of the incoming ring address
	assign addrIndex = IndexBits'(lineIndex(lineAddress(readAddr), IndexBits));

	always_ff @(posedge clock)
	begin
		if (reset)
			validBits <= '0;
		else if (writeEnable)
			validBits[writeIndex] <= 1'b1;
	end

	always_ff @(posedge clock)
	begin
		if (writeEnable)
		begin
			dataArray[writeIndex] <= writeLine;
			tagArray[writeIndex] <= writeTag;
			dirtyBits[writeIndex] <= writeDirty;
		end
	end

	// registered read, same-edge write is not seen
	always_ff @(posedge clock)
	begin
		readLine <= dataArray[addrIndex];
		readTag <= tagArray[addrIndex];
		readDirty <= dirtyBits[addrIndex];
		readValid <= validBits[addrIndex];
		readIndex <= addrIndex;
	end

endmodule

//--- source/accessControl.sv
module accessControl #(
	parameter int IndexBits = 6
) (
	input logic clock,
	input logic reset,
	input logic [l2TilePkg::opmWidth-1:0] reqOpm,
	input logic [l2TilePkg::addrWidth-1:0] reqAddr,
	input logic [l2TilePkg::wordWidth-1:0] reqData,
	input logic reqRamReq,
	input l2TilePkg::tile_u readLine,
	input logic [l2TilePkg::lineAddrWidth-1:0] readTag,
	input logic readValid,
	input logic readDirty,
	input logic [IndexBits-1:0] readIndex,
	output logic writeEnable,
	output logic [IndexBits-1:0] writeIndex,
	output l2TilePkg::tile_u writeLine,
	output logic [l2TilePkg::lineAddrWidth-1:0] writeTag,
	output logic writeDirty,
	output logic respond,
	output logic [l2TilePkg::wordWidth-1:0] respondWord,
	output logic fillStart,
	output logic [IndexBits-1:0] fillIndex,
	output logic [l2TilePkg::lineAddrWidth-1:0] fillLineAddr,
	output logic [l2TilePkg::lineAddrWidth-1:0] victimTag,
	output l2TilePkg::tile_u victimLine,
	output logic victimDirty,
	input logic accessBusy,
	input logic [IndexBits-1:0] busyIndex,
	input logic fillDone,
	input l2TilePkg::tile_u fillLine
);
	import l2TilePkg::*;

	logic [lineAddrWidth-1:0] reqLineAddr;
	logic [1:0] wordSel;
	logic isStore;
	logic hazard;
	logic tagHit;
	logic loadHit;
	logic storeHit;
	tile_u mergedLine;
	logic lastWriteEnable;
	logic [IndexBits-1:0] lastWriteIndex;
	logic [lineAddrWidth-1:0] pendTag;

	assign reqLineAddr = lineAddress(reqAddr);
	assign wordSel = wordSelect(reqAddr);
	assign isStore = reqOpm[7:0] == opStore;

	// line in flight, or read raced with last cycle's write
	assign hazard = (accessBusy && (readIndex == busyIndex)) ||
		(lastWriteEnable && (lastWriteIndex == readIndex));

	assign tagHit = readValid && (readTag == reqLineAddr);
	assign loadHit = reqRamReq && !hazard && tagHit && !isStore;
	// the fill owns the write port this cycle
	assign storeHit = reqRamReq && !hazard && tagHit && isStore && !fillDone;

	assign fillStart = reqRamReq && !hazard && !tagHit && !accessBusy;
	assign fillIndex = readIndex;
	assign fillLineAddr = reqLineAddr;
	assign victimTag = readTag;
	assign victimLine = readLine;
	assign victimDirty = readValid && readDirty;

	always_comb
	begin
		mergedLine = readLine;
		if (isStore)
			mergedLine.word[wordSel] = reqData;
	end

	always_comb
	begin
		writeEnable = storeHit;
		writeIndex = readIndex;
		writeLine = mergedLine;
		writeTag = reqLineAddr;
		writeDirty = 1'b1;
		if (fillDone)
		begin
			writeEnable = 1'b1;
			writeIndex = busyIndex;
			writeLine = fillLine;
			writeTag = pendTag;
			writeDirty = 1'b0;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			respond <= 1'b0;
			lastWriteEnable <= 1'b0;
		end
		else
		begin
			respond <= loadHit || storeHit;
			lastWriteEnable <= writeEnable;
		end
	end

	always_ff @(posedge clock)
	begin
		// store response echoes the stored word
		respondWord <= mergedLine.word[wordSel];
		lastWriteIndex <= writeIndex;
		if (fillStart)
			pendTag <= reqLineAddr;
	end

endmodule

//--- source/ddrTileAccess.sv
module ddrTileAccess #(
	parameter int IndexBits = 6
) (
	input logic clock,
	input logic reset,
	input logic fillStart,
	input logic [IndexBits-1:0] fillIndex,
	input logic [l2TilePkg::lineAddrWidth-1:0] fillLineAddr,
	input logic [l2TilePkg::lineAddrWidth-1:0] victimTag,
	input l2TilePkg::tile_u victimLine,
	input logic victimDirty,
	output logic accessBusy,
	output logic [IndexBits-1:0] busyIndex,
	output logic fillDone,
	output l2TilePkg::tile_u fillLine,
	output logic [l2TilePkg::ddrAddrWidth-1:0] ddrAddr,
	output logic [l2TilePkg::ddrOpmWidth-1:0] ddrOpm,
	output logic [l2TilePkg::tileWidth-1:0] ddrDataOut,
	input logic [l2TilePkg::tileWidth-1:0] ddrDataIn,
	input logic [l2TilePkg::ddrOkWidth-1:0] ddrOk
);
	import l2TilePkg::*;

	localparam logic [2:0] StIdle = 3'd0;
	localparam logic [2:0] StWaitWrite = 3'd1;
	localparam logic [2:0] StWrite = 3'd2;
	localparam logic [2:0] StWaitRead = 3'd3;
	localparam logic [2:0] StRead = 3'd4;
	localparam logic [2:0] StDone = 3'd5;

	logic [2:0] state;
	logic [lineAddrWidth-1:0] pendLineAddr;
	logic [lineAddrWidth-1:0] pendTag;
	logic issueNow;
	logic okNow;

	assign accessBusy = state != StIdle;
	// one cycle, still busy, so the index stays guarded
	assign fillDone = state == StDone;
	assign issueNow = ddrOk == ddrStReady;
	assign okNow = ddrOk == ddrStOk;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= StIdle;
			ddrOpm <= ddrReady;
		end
		else
		begin
			case (state)
				StIdle:
					if (fillStart)
						state <= victimDirty ? StWaitWrite : StWaitRead;
				StWaitWrite:
					if (issueNow)
					begin
						ddrOpm <= ddrWriteTile;
						state <= StWrite;
					end
				StWrite:
					if (okNow)
					begin
						ddrOpm <= ddrReady;
						state <= StWaitRead;
					end
				StWaitRead:
					// also waits out the release of the writeback
					if (issueNow)
					begin
						ddrOpm <= ddrReadTile;
						state <= StRead;
					end
				StRead:
					if (okNow)
					begin
						ddrOpm <= ddrReady;
						state <= StDone;
					end
				default:
					state <= StIdle;
			endcase
		end
	end

	// nothing here moves while DDR holds
	always_ff @(posedge clock)
	begin
		if ((state == StIdle) && fillStart)
		begin
			busyIndex <= fillIndex;
			pendLineAddr <= fillLineAddr;
			pendTag <= victimTag;
			ddrDataOut <= victimLine.flat;
		end
		if ((state == StWaitWrite) && issueNow)
			ddrAddr <= {pendTag, 6'b000000};
		if ((state == StWaitRead) && issueNow)
			ddrAddr <= {pendLineAddr, 6'b000000};
		if ((state == StRead) && okNow)
			fillLine.flat <= ddrDataIn;
	end

endmodule

//--- source/l2TileCache.sv
module l2TileCache #(
	parameter int IndexBits = 6
) (
	input logic clock,
	input logic reset,
	input logic [l2TilePkg::seqWidth-1:0] seqIn,
	input logic [l2TilePkg::opmWidth-1:0] opmIn,
	input logic [l2TilePkg::addrWidth-1:0] addrIn,
	input logic [l2TilePkg::wordWidth-1:0] dataIn,
	output logic [l2TilePkg::seqWidth-1:0] seqOut,
	output logic [l2TilePkg::opmWidth-1:0] opmOut,
	output logic [l2TilePkg::addrWidth-1:0] addrOut,
	output logic [l2TilePkg::wordWidth-1:0] dataOut,
	output logic [l2TilePkg::ddrAddrWidth-1:0] ddrAddr,
	output logic [l2TilePkg::ddrOpmWidth-1:0] ddrOpm,
	output logic [l2TilePkg::tileWidth-1:0] ddrDataOut,
	input logic [l2TilePkg::tileWidth-1:0] ddrDataIn,
	input logic [l2TilePkg::ddrOkWidth-1:0] ddrOk
);
	import l2TilePkg::*;

	// stage-2 view of the ring message
	logic [opmWidth-1:0] stage2Opm;
	logic [addrWidth-1:0] stage2Addr;
	logic [wordWidth-1:0] stage2Data;
	logic stage2RamReq;

	// line store read and write ports
	tile_u readLine;
	logic [lineAddrWidth-1:0] readTag;
	logic readValid;
	logic readDirty;
	logic [IndexBits-1:0] readIndex;
	logic writeEnable;
	logic [IndexBits-1:0] writeIndex;
	tile_u writeLine;
	logic [lineAddrWidth-1:0] writeTag;
	logic writeDirty;

	logic respond;
	logic [wordWidth-1:0] respondWord;

	// miss launch and fill return
	logic fillStart;
	logic [IndexBits-1:0] fillIndex;
	logic [lineAddrWidth-1:0] fillLineAddr;
	logic [lineAddrWidth-1:0] victimTag;
	tile_u victimLine;
	logic victimDirty;
	logic accessBusy;
	logic [IndexBits-1:0] busyIndex;
	logic fillDone;
	tile_u fillLine;

	ringStages u_ringStages (
		.clock(clock), .reset(reset),
		.seqIn(seqIn), .opmIn(opmIn), .addrIn(addrIn), .dataIn(dataIn),
		.seqOut(seqOut), .opmOut(opmOut), .addrOut(addrOut), .dataOut(dataOut),
		.respond(respond), .respondWord(respondWord),
		.stage2Opm(stage2Opm), .stage2Addr(stage2Addr), .stage2Data(stage2Data),
		.stage2RamReq(stage2RamReq)
	);

	lineStore #(.IndexBits(IndexBits)) u_lineStore (
		.clock(clock), .reset(reset), .readAddr(addrIn),
		.readLine(readLine), .readTag(readTag), .readValid(readValid),
		.readDirty(readDirty), .readIndex(readIndex),
		.writeEnable(writeEnable), .writeIndex(writeIndex), .writeLine(writeLine),
		.writeTag(writeTag), .writeDirty(writeDirty)
	);

	accessControl #(.IndexBits(IndexBits)) u_accessControl (
		.clock(clock), .reset(reset),
		.reqOpm(stage2Opm), .reqAddr(stage2Addr), .reqData(stage2Data),
		.reqRamReq(stage2RamReq),
		.readLine(readLine), .readTag(readTag), .readValid(readValid),
		.readDirty(readDirty), .readIndex(readIndex),
		.writeEnable(writeEnable), .writeIndex(writeIndex), .writeLine(writeLine),
		.writeTag(writeTag), .writeDirty(writeDirty),
		.respond(respond), .respondWord(respondWord),
		.fillStart(fillStart), .fillIndex(fillIndex), .fillLineAddr(fillLineAddr),
		.victimTag(victimTag), .victimLine(victimLine), .victimDirty(victimDirty),
		.accessBusy(accessBusy), .busyIndex(busyIndex),
		.fillDone(fillDone), .fillLine(fillLine)
	);

	ddrTileAccess #(.IndexBits(IndexBits)) u_ddrTileAccess (
		.clock(clock), .reset(reset),
		.fillStart(fillStart), .fillIndex(fillIndex), .fillLineAddr(fillLineAddr),
		.victimTag(victimTag), .victimLine(victimLine), .victimDirty(victimDirty),
		.accessBusy(accessBusy), .busyIndex(busyIndex),
		.fillDone(fillDone), .fillLine(fillLine),
		.ddrAddr(ddrAddr), .ddrOpm(ddrOpm), .ddrDataOut(ddrDataOut),
		.ddrDataIn(ddrDataIn), .ddrOk(ddrOk)
	);

endmodule

//--- verif/l2TileCacheSva.sv
module l2TileCacheSva (
	input logic clock,
	input logic reset,
	input logic [l2TilePkg::ddrAddrWidth-1:0] ddrAddr,
	input logic [l2TilePkg::ddrOpmWidth-1:0] ddrOpm,
	input logic [l2TilePkg::tileWidth-1:0] ddrDataOut,
	input logic [l2TilePkg::ddrOkWidth-1:0] ddrOk,
	input logic accessBusy,
	input logic fillDone
);
	timeunit 1ns;
	timeprecision 1ps;
	import l2TilePkg::*;

	// DDR outputs frozen during hold
	holdStable: assert property (@(posedge clock) disable iff (reset)
		(ddrOk == ddrStHold) |=> ($stable(ddrAddr) && $stable(ddrOpm) && $stable(ddrDataOut)))
		else $error("DDR outputs moved during hold");

	// engine at rest keeps the DDR op at ready, first cycle after reset included
	idleReady: assert property (@(posedge clock) disable iff (reset)
		!accessBusy |-> (ddrOpm == ddrReady))
		else $error("DDR op not ready while the engine is idle");

	// a fill ends only on an acknowledged tile read of a running access
	doneAfterRead: assert property (@(posedge clock) disable iff (reset)
		fillDone |-> (accessBusy && $past(ddrOpm == ddrReadTile) && $past(ddrOk == ddrStOk)))
		else $error("fill done without an acknowledged tile read");

endmodule

bind ddrTileAccess l2TileCacheSva u_l2TileCacheSva (.*);

//--- verif/l2TileCacheTb.sv
module l2TileCacheTb;
	timeunit 1ns;
	timeprecision 1ps;
	import l2TilePkg::*;

	localparam int RandomRequests = 40;
	localparam int PlannedRequests = 10 + RandomRequests;
	localparam int RetryBound = 40;
	localparam logic [7:0] opPrefetch = 8'hC3;

	logic clock = 1'b0;
	logic reset;
	logic [seqWidth-1:0] seqIn;
	logic [opmWidth-1:0] opmIn;
	logic [addrWidth-1:0] addrIn;
	logic [wordWidth-1:0] dataIn;
	logic [seqWidth-1:0] seqOut;
	logic [opmWidth-1:0] opmOut;
	logic [addrWidth-1:0] addrOut;
	logic [wordWidth-1:0] dataOut;
	logic [ddrAddrWidth-1:0] ddrAddr;
	logic [ddrOpmWidth-1:0] ddrOpm;
	logic [tileWidth-1:0] ddrDataOut;
	logic [tileWidth-1:0] ddrDataIn;
	logic [ddrOkWidth-1:0] ddrOk;

	logic [31:0] rngState = 32'd96;
	logic [tileWidth-1:0] ddrMem [logic [31:0]];
	logic [wordWidth-1:0] shadow [logic [27:0]];
	// bit 32 set for a tile write
	logic [32:0] opLog [$];
	logic [seqWidth-1:0] qSeq [$];
	logic [opmWidth-1:0] qOpm [$];
	logic [addrWidth-1:0] qAddr [$];
	logic [wordWidth-1:0] qData [$];
	int errorCount = 0;
	int testsRun = 0;
	int testsFailed = 0;
	logic responded = 1'b0;
	logic [seqWidth-1:0] nextSeq = '0;

	l2TileCache u_l2TileCache (.*);

	always #50 clock = ~clock;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function logic [31:0] nextRandom();
		rngState = xorshift(rngState);
		return rngState;
	endfunction

	// initial DDR content, every word tied to its tile address
	function automatic logic [tileWidth-1:0] patternTile(input logic [31:0] addr);
		logic [tileWidth-1:0] t;
		for (int w = 0; w < 4; w++)
			t[w*128 +: 128] = {addr, ~addr, addr ^ 32'h9e3779b9, 28'h0, 2'(w), 2'b00};
		return t;
	endfunction

	function automatic logic [wordWidth-1:0] refWord(input logic [addrWidth-1:0] addr);
		logic [31:0] tileAddr;
		logic [tileWidth-1:0] tile;
		tileAddr = {addr[31:6], 6'b000000};
		if (shadow.exists(addr[31:4]))
			return shadow[addr[31:4]];
		tile = ddrMem.exists(tileAddr) ? ddrMem[tileAddr] : patternTile(tileAddr);
		return tile[addr[5:4]*128 +: 128];
	endfunction

	function automatic logic isRequest(input logic [15:0] opm, input logic [47:0] addr);
		return ((opm[7:0] == opLoad) || (opm[7:0] == opStore)) &&
			(addr[29:24] != 6'h00) && (addr[31:30] == 2'b00);
	endfunction

	task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
		if (got !== exp)
		begin
			$display("Fail %s: got %h expected %h", name, got, exp);
			errorCount++;
		end
	endtask

	// input message as latched by the DUT
	always @(posedge clock)
	begin
		if (!reset)
		begin
			qSeq.push_back(seqIn);
			qOpm.push_back(opmIn);
			qAddr.push_back(addrIn);
			qData.push_back(dataIn);
		end
	end

	always @(negedge clock)
	begin
		logic [seqWidth-1:0] eSeq;
		logic [opmWidth-1:0] eOpm;
		logic [addrWidth-1:0] eAddr;
		logic [wordWidth-1:0] eData;
		logic isOk;
		if (qOpm.size() >= 3)
		begin
			eSeq = qSeq.pop_front();
			eOpm = qOpm.pop_front();
			eAddr = qAddr.pop_front();
			eData = qData.pop_front();
			isOk = (opmOut[7:0] == opOkLoad) || (opmOut[7:0] == opOkStore);
			if (isRequest(eOpm, eAddr) && isOk)
			begin
				check("seqOut", seqOut, eSeq);
				check("addrOut", addrOut, eAddr);
				check("opmOut", opmOut, {eOpm[15:8],
					(eOpm[7:0] == opStore) ? opOkStore : opOkLoad});
				if (eOpm[7:0] == opStore)
				begin
					check("dataOut", dataOut, eData);
					shadow[eAddr[31:4]] = eData;
				end
				else
					check("dataOut", dataOut, refWord(eAddr));
				responded = 1'b1;
			end
			else
			begin
				check("seqOut", seqOut, eSeq);
				check("opmOut", opmOut, eOpm);
				check("addrOut", addrOut, eAddr);
				check("dataOut", dataOut, eData);
			end
		end
	end

	// DDR memory model
	initial
	begin
		logic [31:0] ddrRng;
		int delay;
		ddrRng = 32'd96 ^ 32'h0000abcd;
		ddrOk = ddrStReady;
		ddrDataIn = '0;
		forever
		begin
			@(negedge clock);
			if (!reset && (ddrOpm != ddrReady))
			begin
				ddrRng = xorshift(ddrRng);
				delay = 1 + int'(ddrRng[1:0]) + int'(ddrRng[5:4]);
				ddrOk = ddrStHold;
				repeat (delay) @(negedge clock);
				if (ddrOpm == ddrWriteTile)
				begin
					ddrMem[ddrAddr] = ddrDataOut;
					opLog.push_back({1'b1, ddrAddr});
				end
				else
				begin
					ddrDataIn = ddrMem.exists(ddrAddr) ? ddrMem[ddrAddr] : patternTile(ddrAddr);
					opLog.push_back({1'b0, ddrAddr});
				end
				ddrOk = ddrStOk;
				@(negedge clock);
				ddrOk = ddrStReady;
			end
		end
	end

	task automatic driveMessage(input logic [7:0] op, input logic [47:0] addr,
		input logic [127:0] data);
		@(negedge clock);
		seqIn = nextSeq;
		opmIn = {nextSeq[7:0] ^ 8'h3c, op};
		addrIn = addr;
		dataIn = data;
		nextSeq++;
	endtask

	// idle, non-RAM or prefetch traffic
	task automatic sendFiller();
		logic [31:0] r;
		r = nextRandom();
		case (r[1:0])
			2'd0: driveMessage(opIdle, 48'(r), {4{r}});
			2'd1: driveMessage(opLoad, {16'h0, 2'b01, r[29:0]}, {4{~r}});
			2'd2: driveMessage(opPrefetch, {16'h0, 8'h01, r[23:0]}, {4{r}});
			default: driveMessage(opStore, {16'h0, 8'h00, r[23:0]}, {4{r}});
		endcase
	endtask

	task automatic request(input logic [7:0] op, input logic [47:0] addr,
		input logic [127:0] data, output logic firstResponded);
		int waited;
		int extra;
		logic first;
		waited = 0;
		first = 1'b1;
		responded = 1'b0;
		firstResponded = 1'b0;
		while (!responded && (waited < RetryBound))
		begin
			driveMessage(op, addr, data);
			repeat (3) sendFiller();
			extra = int'(nextRandom() % 2);
			repeat (extra) sendFiller();
			#10;
			waited += 4 + extra;
			if (first)
				firstResponded = responded;
			first = 1'b0;
		end
		if (!responded)
		begin
			$display("request %h to address %h got no response within %0d cycles",
				op, addr, RetryBound);
			errorCount++;
		end
	endtask

	task automatic finishTest(input string name, input int startErrors);
		testsRun++;
		if (errorCount == startErrors)
			$display("test %s: ok", name);
		else
		begin
			testsFailed++;
			$display("test %s: FAILED with %0d errors", name, errorCount - startErrors);
		end
	endtask

	initial
	begin
		repeat (16 + 60 * PlannedRequests + 200) @(posedge clock);
		$display("watchdog expired before the tests finished");
		$display("sim failed");
		$finish;
	end

	initial
	begin
		int startErrors;
		int writeAt;
		int readAt;
		logic first;
		logic [25:0] lineA;
		logic [25:0] lineB;
		logic [25:0] line;
		logic [31:0] r;
		reset = 1'b1;
		seqIn = '0;
		opmIn = '0;
		addrIn = '0;
		dataIn = '0;
		repeat (16) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		startErrors = errorCount;
		repeat (20) sendFiller();
		driveMessage(opIdle, '0, '0);
		repeat (3) sendFiller();
		#10;
		finishTest("forward", startErrors);

		startErrors = errorCount;
		request(opLoad, 48'h0000_0200_0040, '0, first);
		if (first)
		begin
			$display("first load to an empty line was answered instead of forwarded");
			errorCount++;
		end
		finishTest("load miss then hit", startErrors);

		startErrors = errorCount;
		request(opStore, 48'h0000_0300_0090, 128'h1111_2222_3333_4444_5555_6666_7777_8888, first);
		request(opLoad, 48'h0000_0300_0090, '0, first);
		request(opStore, 48'h0000_0300_0080, 128'hA0, first);
		request(opStore, 48'h0000_0300_00A0, 128'hA2, first);
		request(opStore, 48'h0000_0300_00B0, 128'hA3, first);
		request(opLoad, 48'h0000_0300_0090, '0, first);
		finishTest("store then load", startErrors);

		startErrors = errorCount;
		lineA = 26'h0100000;
		lineB = lineA ^ 26'h0000041;
		request(opStore, {16'h0, lineA, 6'h10}, 128'hDEAD_BEEF_0000_0001, first);
		opLog.delete();
		request(opLoad, {16'h0, lineB, 6'h00}, '0, first);
		writeAt = -1;
		readAt = -1;
		foreach (opLog[i])
		begin
			if (opLog[i] == {1'b1, lineA, 6'h00} && writeAt < 0)
				writeAt = i;
			if (opLog[i] == {1'b0, lineB, 6'h00} && readAt < 0)
				readAt = i;
		end
		if ((writeAt < 0) || (readAt < 0) || (writeAt > readAt))
		begin
			$display("dirty victim was not written back before the new tile was read");
			errorCount++;
		end
		request(opLoad, {16'h0, lineA, 6'h10}, '0, first);
		finishTest("victim writeback", startErrors);

		startErrors = errorCount;
		for (int i = 0; i < RandomRequests; i++)
		begin
			r = nextRandom();
			line = 26'h0100000 + 26'(r[6:0]);
			if (r[7])
				request(opStore, {16'h0, line, r[9:8], 4'h0},
					{nextRandom(), nextRandom(), nextRandom(), r}, first);
			else
				request(opLoad, {16'h0, line, r[9:8], 4'h0}, '0, first);
			repeat (int'(r[11:10])) sendFiller();
		end
		repeat (3) sendFiller();
		#10;
		finishTest("random traffic", startErrors);

		$display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
		if (errorCount == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

//--- filelist.f
source/l2TilePkg.sv
source/ringStages.sv
source/lineStore.sv
source/accessControl.sv
source/ddrTileAccess.sv
source/l2TileCache.sv
verif/l2TileCacheSva.sv
verif/l2TileCacheTb.sv

//--- run.sh
#!/bin/sh
# build and run the cache tile testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module l2TileCacheTb -f filelist.f -o l2TileCacheSim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/l2TileCacheSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
	exit 0
fi
exit 1
